// ==== verilog/fetch_pkg.sv ====
// fetch front end shared constants

package fetch_pkg;

  // datapath widths
  parameter int unsigned INST_WD      = 32;
  parameter int unsigned PC_WD        = 64;
  parameter int unsigned SRAM_DATA_WD = 64; // two instructions per word
  parameter int unsigned SRAM_ADDR_WD = 64;

  // register block bus
  parameter int unsigned WB_ADR_WD    = 4;
  parameter int unsigned WB_DAT_WD    = 64;

  // register byte offsets
  parameter logic [3:0] REG_CTRL      = 4'h0; // bit 0 fetch enable
  parameter logic [3:0] REG_BOOT_PC   = 4'h4;
  parameter logic [3:0] REG_FETCH_CNT = 4'h8; // read only
  parameter logic [3:0] REG_STALL_CNT = 4'hc; // read only

  // boot pc after reset
  parameter logic [63:0] PC_RESETVAL  = 64'h8000_0000;

endpackage

// ==== verilog/fetch_pc.sv ====
// fetch program counter

module fetch_pc import fetch_pkg::*; #(
  parameter int PC_WD        = 64,
  parameter int SRAM_ADDR_WD = 64
) (
  input  logic                    i_clk,
  input  logic                    i_rst_n,
  // boot pc from the register block
  input  logic                    i_boot_load,
  input  logic [PC_WD-1:0]        i_boot_pc,
  // request accepted by the sram
  input  logic                    i_load,
  // redirect from decode
  input  logic                    i_br_taken,
  input  logic [PC_WD-1:0]        i_br_target,
  output logic [PC_WD-1:0]        o_pc,
  output logic [SRAM_ADDR_WD-1:0] o_inst_sram_addr
);

  logic [PC_WD-1:0] pc_q; // pc of the next request
  logic [PC_WD-1:0] pc_d;

  always_comb begin
    pc_d = pc_q;
    if (i_boot_load) begin
      pc_d = i_boot_pc;
    end else if (i_br_taken) begin
      pc_d = i_br_target;
    end else if (i_load) begin
      pc_d = pc_q + PC_WD'(4);
    end
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      pc_q <= PC_WD'(PC_RESETVAL);
    end else begin
      pc_q <= pc_d;
    end
  end

  assign o_pc = pc_q;

  // sram word is 64 bit aligned
  assign o_inst_sram_addr = {pc_q[SRAM_ADDR_WD-1:3], 3'b000};

endmodule

// ==== verilog/fetch_stage.sv ====
// instruction fetch stage

module fetch_stage #(
  parameter int INST_WD      = 32,
  parameter int PC_WD        = 64,
  parameter int SRAM_ADDR_WD = 64,
  parameter int SRAM_DATA_WD = 64
) (
  input  logic                    i_clk,
  input  logic                    i_rst_n,
  // control from the register block
  input  logic                    i_fetch_en,
  input  logic                    i_boot_load,
  input  logic [PC_WD-1:0]        i_boot_pc,
  // decode side
  input  logic                    i_ds_allowin,
  input  logic                    i_br_stall,  // load-to-branch stall blocks new fetch
  input  logic                    i_br_taken,
  input  logic [PC_WD-1:0]        i_br_target,
  output logic                    o_fs_to_ds_valid,
  output logic [INST_WD-1:0]      o_fs_inst,
  output logic [PC_WD-1:0]        o_fs_pc,
  // events for the counters
  output logic                    o_deliver,
  output logic                    o_ds_stall,
  // inst sram interface
  output logic                    o_inst_sram_ren,
  output logic [SRAM_ADDR_WD-1:0] o_inst_sram_addr,
  input  logic [SRAM_DATA_WD-1:0] i_inst_sram_rdata,
  input  logic                    i_inst_sram_addr_ok,
  input  logic                    i_inst_sram_data_ok
);

  logic               redirect;
  logic               boot_settle;
  logic [PC_WD-1:0]   pc;
  logic               pre_fs_ready_go;
  logic               req_accept;
  logic               req_pending;   // one request in flight
  logic               req_cancel;    // in-flight response is stale
  logic [PC_WD-1:0]   req_pc;
  logic               rsp_take;
  logic [INST_WD-1:0] inst_sel;
  logic               fs_valid;
  logic               fs_allowin;
  logic [INST_WD-1:0] fs_inst;
  logic [PC_WD-1:0]   fs_pc;

  // boot load restarts fetch just like a taken branch
  assign redirect = i_br_taken | i_boot_load;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      boot_settle <= 1'b0;
    end else begin
      boot_settle <= i_boot_load; // pc shows boot value here
    end
  end

  // pre-if stage
  assign pre_fs_ready_go = i_fetch_en & ~i_br_stall & ~req_pending
                         & ~boot_settle & ~redirect;
  assign o_inst_sram_ren = pre_fs_ready_go & fs_allowin;
  assign req_accept      = o_inst_sram_ren & i_inst_sram_addr_ok;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      req_pending <= 1'b0;
      req_cancel  <= 1'b0;
    end else begin
      if (req_accept) begin
        req_pending <= 1'b1;
      end else if (i_inst_sram_data_ok) begin
        req_pending <= 1'b0;
      end
      // a redirect overtakes the pending response
      if (i_inst_sram_data_ok) begin
        req_cancel <= 1'b0;
      end else if (redirect && req_pending) begin
        req_cancel <= 1'b1;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (req_accept) begin
      req_pc <= pc;
    end
  end

  // if stage
  assign rsp_take = i_inst_sram_data_ok & req_pending & ~req_cancel & ~redirect;

  // pc[2] picks the upper instruction of the word
  assign inst_sel = req_pc[2] ? i_inst_sram_rdata[SRAM_DATA_WD-1 -: INST_WD]
                              : i_inst_sram_rdata[INST_WD-1:0];

  assign fs_allowin = ~fs_valid | i_ds_allowin;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      fs_valid <= 1'b0;
    end else if (redirect) begin
      fs_valid <= 1'b0;  // held instruction is on the wrong path
    end else if (rsp_take) begin
      fs_valid <= 1'b1;
    end else if (i_ds_allowin) begin
      fs_valid <= 1'b0;
    end
  end

  // save buffer stays put while decode blocks
  always_ff @(posedge i_clk) begin
    if (rsp_take) begin
      fs_inst <= inst_sel;
      fs_pc   <= req_pc;
    end
  end

  assign o_fs_to_ds_valid = fs_valid;
  assign o_fs_inst        = fs_inst;
  assign o_fs_pc          = fs_pc;

  assign o_deliver  = fs_valid & i_ds_allowin;
  assign o_ds_stall = fs_valid & ~i_ds_allowin;

  fetch_pc #(
    .PC_WD            (PC_WD           ),
    .SRAM_ADDR_WD     (SRAM_ADDR_WD    )
  ) u_pc (
    .i_clk            (i_clk           ),
    .i_rst_n          (i_rst_n         ),
    .i_boot_load      (i_boot_load     ),
    .i_boot_pc        (i_boot_pc       ),
    .i_load           (req_accept      ), // advance once the sram takes it
    .i_br_taken       (i_br_taken      ),
    .i_br_target      (i_br_target     ),
    .o_pc             (pc              ),
    .o_inst_sram_addr (o_inst_sram_addr)
  );

endmodule

// ==== verilog/fetch_csr.sv ====
// fetch control registers

module fetch_csr import fetch_pkg::*; #(
  parameter int WB_ADR_WD = 4,
  parameter int WB_DAT_WD = 64,
  parameter int PC_WD     = 64
) (
  input  logic                 i_clk,
  input  logic                 i_rst_n,
  // wishbone classic slave
  input  logic                 i_wb_cyc,
  input  logic                 i_wb_stb,
  input  logic                 i_wb_we,
  input  logic [WB_ADR_WD-1:0] i_wb_adr,
  input  logic [WB_DAT_WD-1:0] i_wb_dat,
  output logic [WB_DAT_WD-1:0] o_wb_dat,
  output logic                 o_wb_ack,
  // events from the fetch stage
  input  logic                 i_deliver,
  input  logic                 i_ds_stall,
  // fetch control
  output logic                 o_fetch_en,
  output logic                 o_boot_load,
  output logic [PC_WD-1:0]     o_boot_pc
);

  logic                 wb_req;
  logic                 wb_wr;
  logic                 ack_q;
  logic [WB_DAT_WD-1:0] rd_data;
  logic [WB_DAT_WD-1:0] rd_q;
  logic                 fetch_en;
  logic                 fetch_en_q;
  logic [PC_WD-1:0]     boot_pc;
  logic [WB_DAT_WD-1:0] fetch_cnt;
  logic [WB_DAT_WD-1:0] stall_cnt;

  // no new cycle while ack is out
  assign wb_req = i_wb_cyc & i_wb_stb & ~ack_q;
  assign wb_wr  = wb_req & i_wb_we;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= wb_req;
    end
  end

  // writable registers
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      fetch_en <= 1'b0;
      boot_pc  <= PC_WD'(PC_RESETVAL);
    end else if (wb_wr) begin
      if (i_wb_adr == WB_ADR_WD'(REG_CTRL)) begin
        fetch_en <= i_wb_dat[0];
      end
      if (i_wb_adr == WB_ADR_WD'(REG_BOOT_PC)) begin
        boot_pc <= PC_WD'(i_wb_dat);
      end
    end
  end

  // enable edge detect for the boot load
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      fetch_en_q <= 1'b0;
    end else begin
      fetch_en_q <= fetch_en;
    end
  end

  // event counters
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      fetch_cnt <= '0;
      stall_cnt <= '0;
    end else begin
      if (i_deliver) begin
        fetch_cnt <= fetch_cnt + WB_DAT_WD'(1);
      end
      if (i_ds_stall) begin
        stall_cnt <= stall_cnt + WB_DAT_WD'(1);
      end
    end
  end

  always_comb begin
    case (i_wb_adr)
      WB_ADR_WD'(REG_CTRL):      rd_data = {{(WB_DAT_WD-1){1'b0}}, fetch_en};
      WB_ADR_WD'(REG_BOOT_PC):   rd_data = WB_DAT_WD'(boot_pc);
      WB_ADR_WD'(REG_FETCH_CNT): rd_data = fetch_cnt;
      WB_ADR_WD'(REG_STALL_CNT): rd_data = stall_cnt;
      default:                   rd_data = '0; // unmapped
    endcase
  end

  // read data lines up with ack
  always_ff @(posedge i_clk) begin
    if (wb_req) begin
      rd_q <= rd_data;
    end
  end

  assign o_wb_dat    = rd_q;
  assign o_wb_ack    = ack_q;
  assign o_fetch_en  = fetch_en;
  assign o_boot_load = fetch_en & ~fetch_en_q;
  assign o_boot_pc   = boot_pc;

endmodule

// ==== verilog/fetch_top.sv ====
// instruction fetch front end

module fetch_top import fetch_pkg::*; (
  input  logic                    i_clk,
  input  logic                    i_rst_n,
  // wishbone register port
  input  logic                    i_wb_cyc,
  input  logic                    i_wb_stb,
  input  logic                    i_wb_we,
  input  logic [WB_ADR_WD-1:0]    i_wb_adr,
  input  logic [WB_DAT_WD-1:0]    i_wb_dat,
  output logic [WB_DAT_WD-1:0]    o_wb_dat,
  output logic                    o_wb_ack,
  // inst sram interface
  output logic                    o_inst_sram_ren,
  output logic [SRAM_ADDR_WD-1:0] o_inst_sram_addr,
  input  logic [SRAM_DATA_WD-1:0] i_inst_sram_rdata,
  input  logic                    i_inst_sram_addr_ok,
  input  logic                    i_inst_sram_data_ok,
  // decode side
  input  logic                    i_ds_allowin,
  input  logic                    i_br_stall,
  input  logic                    i_br_taken,
  input  logic [PC_WD-1:0]        i_br_target,
  output logic                    o_fs_to_ds_valid,
  output logic [INST_WD-1:0]      o_fs_inst,
  output logic [PC_WD-1:0]        o_fs_pc
);

  logic             fetch_en;
  logic             boot_load;
  logic [PC_WD-1:0] boot_pc;
  logic             deliver;
  logic             ds_stall;

  fetch_csr #(
    .WB_ADR_WD   (WB_ADR_WD),
    .WB_DAT_WD   (WB_DAT_WD),
    .PC_WD       (PC_WD    )
  ) u_csr (
    .i_clk       (i_clk    ),
    .i_rst_n     (i_rst_n  ),
    .i_wb_cyc    (i_wb_cyc ),
    .i_wb_stb    (i_wb_stb ),
    .i_wb_we     (i_wb_we  ),
    .i_wb_adr    (i_wb_adr ),
    .i_wb_dat    (i_wb_dat ),
    .o_wb_dat    (o_wb_dat ),
    .o_wb_ack    (o_wb_ack ),
    .i_deliver   (deliver  ),
    .i_ds_stall  (ds_stall ),
    .o_fetch_en  (fetch_en ),
    .o_boot_load (boot_load),
    .o_boot_pc   (boot_pc  )
  );

  fetch_stage #(
    .INST_WD             (INST_WD            ),
    .PC_WD               (PC_WD              ),
    .SRAM_ADDR_WD        (SRAM_ADDR_WD       ),
    .SRAM_DATA_WD        (SRAM_DATA_WD       )
  ) u_stage (
    .i_clk               (i_clk              ),
    .i_rst_n             (i_rst_n            ),
    .i_fetch_en          (fetch_en           ),
    .i_boot_load         (boot_load          ),
    .i_boot_pc           (boot_pc            ),
    .i_ds_allowin        (i_ds_allowin       ),
    .i_br_stall          (i_br_stall         ),
    .i_br_taken          (i_br_taken         ),
    .i_br_target         (i_br_target        ),
    .o_fs_to_ds_valid    (o_fs_to_ds_valid   ),
    .o_fs_inst           (o_fs_inst          ),
    .o_fs_pc             (o_fs_pc            ),
    .o_deliver           (deliver            ),
    .o_ds_stall          (ds_stall           ),
    .o_inst_sram_ren     (o_inst_sram_ren    ),
    .o_inst_sram_addr    (o_inst_sram_addr   ),
    .i_inst_sram_rdata   (i_inst_sram_rdata  ),
    .i_inst_sram_addr_ok (i_inst_sram_addr_ok),
    .i_inst_sram_data_ok (i_inst_sram_data_ok)
  );

endmodule

// ==== dv/fetch_props.sv ====
// fetch handshake assertions

module fetch_props (
  input logic        i_clk,
  input logic        i_rst_n,
  input logic        i_valid,
  input logic        i_allowin,
  input logic [31:0] i_inst,
  input logic [63:0] i_pc,
  input logic        i_br_taken,
  input logic        i_ren,
  input logic        i_addr_ok,
  input logic        i_data_ok,
  input logic        i_cyc,
  input logic        i_stb,
  input logic        i_ack
);

  int   fail_cnt = 0;
  logic outstanding; // request accepted and data not yet back

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      outstanding <= 1'b0;
    end else if (i_ren && i_addr_ok) begin
      outstanding <= 1'b1;
    end else if (i_data_ok) begin
      outstanding <= 1'b0;
    end
  end

  a_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_valid && !i_allowin && !i_br_taken |=> i_valid && $stable(i_pc) && $stable(i_inst))
    else begin
      $error("instruction not held under back-pressure");
      fail_cnt++;
    end

  a_one_req: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    outstanding |-> !i_ren)
    else begin
      $error("second sram request while one is outstanding");
      fail_cnt++;
    end

  a_ack: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_cyc && i_stb && !i_ack |=> i_ack)
    else begin
      $error("wishbone ack missing one cycle after stb");
      fail_cnt++;
    end

  a_ack_pulse: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_ack |=> !i_ack)
    else begin
      $error("wishbone ack longer than one cycle");
      fail_cnt++;
    end

endmodule

// ==== dv/fetch_checker.sv ====
// fetch reference model and checker

module fetch_checker import fetch_pkg::*; (
  input  logic        i_clk,
  input  logic        i_rst_n,
  input  logic        i_wb_cyc,
  input  logic        i_wb_stb,
  input  logic        i_wb_we,
  input  logic [3:0]  i_wb_adr,
  input  logic [63:0] i_wb_wdat,
  input  logic [63:0] i_wb_rdat,
  input  logic        i_wb_ack,
  input  logic        i_valid,
  input  logic        i_allowin,
  input  logic [31:0] i_inst,
  input  logic [63:0] i_pc,
  input  logic        i_br_taken,
  input  logic [63:0] i_br_target,
  output int          o_xfer_cnt,
  output int          o_err_cnt
);

  logic [63:0] exp_pc;   // pc of the next instruction decode should see
  logic [63:0] boot_pc;
  logic        en;
  logic        boot_now;
  longint      stall_cnt;
  logic        rd_pend;
  logic [3:0]  rd_adr;
  logic [63:0] rd_exp;

  // each instruction is its pc folded with a constant
  function automatic logic [31:0] inst_of(input logic [63:0] pc);
    return pc[63:32] ^ pc[31:0] ^ 32'h9e37_79b9;
  endfunction

  always @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      exp_pc     = PC_RESETVAL;
      boot_pc    = PC_RESETVAL;
      en         = 1'b0;
      stall_cnt  = 0;
      rd_pend    = 1'b0;
      o_xfer_cnt = 0;
      o_err_cnt  = 0;
    end else begin
      boot_now = 1'b0;
      if (i_wb_ack && rd_pend) begin
        if (i_wb_rdat !== rd_exp) begin
          $display("** Error o_wb_dat at offset %h: %h expected %h", rd_adr, i_wb_rdat, rd_exp);
          o_err_cnt++;
        end
        rd_pend = 1'b0;
      end
      if (i_wb_cyc && i_wb_stb && !i_wb_ack) begin
        if (i_wb_we) begin
          if (i_wb_adr == REG_CTRL) begin
            boot_now = i_wb_wdat[0] && !en; // rising enable reloads the boot pc
            en       = i_wb_wdat[0];
          end else if (i_wb_adr == REG_BOOT_PC) begin
            boot_pc = i_wb_wdat;
          end
        end else begin
          rd_pend = 1'b1;
          rd_adr  = i_wb_adr;
          case (i_wb_adr)
            REG_CTRL:      rd_exp = {63'd0, en};
            REG_BOOT_PC:   rd_exp = boot_pc;
            REG_FETCH_CNT: rd_exp = 64'(o_xfer_cnt);
            REG_STALL_CNT: rd_exp = 64'(stall_cnt);
            default:       rd_exp = '0;
          endcase
        end
      end
      if (i_valid && i_allowin) begin
        if (i_pc !== exp_pc) begin
          $display("** Error o_fs_pc: %h expected %h", i_pc, exp_pc);
          o_err_cnt++;
        end
        if (i_inst !== inst_of(exp_pc)) begin
          $display("** Error o_fs_inst: %h expected %h", i_inst, inst_of(exp_pc));
          o_err_cnt++;
        end
        exp_pc = exp_pc + 64'd4;
        o_xfer_cnt++;
      end
      if (i_valid && !i_allowin) begin
        stall_cnt++;
      end
      if (i_br_taken) begin
        exp_pc = i_br_target;
      end
      if (boot_now) begin
        exp_pc = boot_pc;
      end
    end
  end

endmodule

// ==== dv/tb_fetch.sv ====
// fetch front end testbench

module tb_fetch import fetch_pkg::*;;

  localparam int TOTAL_XFERS = 800;            // sum over all tests
  localparam int CYCLE_LIMIT = 10 * TOTAL_XFERS;

  logic        clk;
  logic        rst_n;
  logic        wb_cyc, wb_stb, wb_we;
  logic [3:0]  wb_adr;
  logic [63:0] wb_wdat, wb_rdat;
  logic        wb_ack;
  logic        sram_ren, addr_ok, data_ok;
  logic [63:0] sram_addr, rdata;
  logic        allowin, br_stall, br_taken;
  logic [63:0] br_target;
  logic        fs_valid;
  logic [31:0] fs_inst;
  logic [63:0] fs_pc;
  int          xfer_cnt, chk_err;
  logic        bp_en, br_en, st_en;        // random stimulus modes
  int          st_len;
  int          cycles = 0;
  int          local_err = 0;
  int          tests_failed = 0;
  logic        pend;
  logic [63:0] pend_addr;
  int          acnt, dcnt;
  int          e0, base;

  fetch_top UUT (
    .i_clk(clk), .i_rst_n(rst_n),
    .i_wb_cyc(wb_cyc), .i_wb_stb(wb_stb), .i_wb_we(wb_we), .i_wb_adr(wb_adr),
    .i_wb_dat(wb_wdat), .o_wb_dat(wb_rdat), .o_wb_ack(wb_ack),
    .o_inst_sram_ren(sram_ren), .o_inst_sram_addr(sram_addr),
    .i_inst_sram_rdata(rdata), .i_inst_sram_addr_ok(addr_ok),
    .i_inst_sram_data_ok(data_ok),
    .i_ds_allowin(allowin), .i_br_stall(br_stall), .i_br_taken(br_taken),
    .i_br_target(br_target), .o_fs_to_ds_valid(fs_valid), .o_fs_inst(fs_inst),
    .o_fs_pc(fs_pc)
  );

  fetch_checker u_chk (
    .i_clk(clk), .i_rst_n(rst_n), .i_wb_cyc(wb_cyc), .i_wb_stb(wb_stb),
    .i_wb_we(wb_we), .i_wb_adr(wb_adr), .i_wb_wdat(wb_wdat), .i_wb_rdat(wb_rdat),
    .i_wb_ack(wb_ack), .i_valid(fs_valid), .i_allowin(allowin), .i_inst(fs_inst),
    .i_pc(fs_pc), .i_br_taken(br_taken), .i_br_target(br_target),
    .o_xfer_cnt(xfer_cnt), .o_err_cnt(chk_err)
  );

  bind fetch_top fetch_props u_props (
    .i_clk(i_clk), .i_rst_n(i_rst_n), .i_valid(o_fs_to_ds_valid),
    .i_allowin(i_ds_allowin), .i_inst(o_fs_inst), .i_pc(o_fs_pc),
    .i_br_taken(i_br_taken), .i_ren(o_inst_sram_ren), .i_addr_ok(i_inst_sram_addr_ok),
    .i_data_ok(i_inst_sram_data_ok), .i_cyc(i_wb_cyc), .i_stb(i_wb_stb), .i_ack(o_wb_ack)
  );

  function automatic logic [31:0] inst_fold(input logic [63:0] pc);
    return pc[63:32] ^ pc[31:0] ^ 32'h9e37_79b9;
  endfunction

  function automatic int total_errs();
    return chk_err + UUT.u_props.fail_cnt + local_err;
  endfunction

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // sram responder with one request in flight
  always @(posedge clk) begin
    if (sram_ren && addr_ok) begin
      if (sram_addr[2:0] !== 3'b000) begin
        $display("** Error o_inst_sram_addr[2:0]: %h expected %h", sram_addr[2:0], 3'h0);
        local_err++;
      end
      pend      = 1'b1;
      pend_addr = sram_addr;
      dcnt      = $urandom % 4;
      acnt      = $urandom % 4;
    end
    #1;
    data_ok = 1'b0;
    if (pend) begin
      if (dcnt == 0) begin
        data_ok = 1'b1;
        rdata   = {inst_fold({pend_addr[63:3], 3'b100}), inst_fold({pend_addr[63:3], 3'b000})};
        pend    = 1'b0;
      end else begin
        dcnt--;
      end
    end
    if (acnt != 0) begin
      addr_ok = 1'b0;
      acnt--;
    end else begin
      addr_ok = 1'b1;
    end
  end

  // decode side stimulus
  always @(posedge clk) begin
    #1;
    allowin   = bp_en ? ($urandom % 4 != 0) : 1'b1;
    br_taken  = br_en && ($urandom % 32 == 0);
    br_target = 64'h8000_0000 + (64'($urandom % 1024) << 2);
    if (st_len > 0) begin
      br_stall = 1'b1;
      st_len--;
    end else begin
      br_stall = 1'b0;
      if (st_en && $urandom % 16 == 0) st_len = 1 + $urandom % 8;
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > CYCLE_LIMIT) begin
      $display("timeout, run exceeded %0d cycles", CYCLE_LIMIT);
      $display("Test FAILED");
      $finish;
    end
  end

  task automatic wb_access(input logic we, input logic [3:0] adr, input logic [63:0] dat);
    @(posedge clk);
    #1;
    wb_cyc  = 1'b1;
    wb_stb  = 1'b1;
    wb_we   = we;
    wb_adr  = adr;
    wb_wdat = dat;
    do @(posedge clk); while (!wb_ack);
    #1;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic run_xfers(input int n);
    int target;
    target = xfer_cnt + n;
    while (xfer_cnt < target) @(posedge clk);
  endtask

  // wait until nothing is held or in flight
  task automatic drain();
    int idle;
    idle = 0;
    while (idle < 8) begin
      @(posedge clk);
      idle = (fs_valid || pend) ? 0 : idle + 1;
    end
  endtask

  task automatic report(input int num, input string name, input int start);
    int e;
    e = total_errs() - start;
    if (e != 0) tests_failed++;
    $display("test %0d %s %s, %0d transfers so far, %0d errors", num, name,
             (e == 0) ? "passed" : "failed", xfer_cnt, e);
  endtask

  initial begin
    void'($urandom(32'hf13a_8faf));
    rst_n     = 1'b0;
    wb_cyc    = 1'b0;
    wb_stb    = 1'b0;
    wb_we     = 1'b0;
    wb_adr    = '0;
    wb_wdat   = '0;
    addr_ok   = 1'b0;
    data_ok   = 1'b0;
    rdata     = '0;
    pend      = 1'b0;
    acnt      = 0;
    dcnt      = 0;
    allowin   = 1'b1;
    br_stall  = 1'b0;
    br_taken  = 1'b0;
    br_target = '0;
    bp_en     = 1'b0;
    br_en     = 1'b0;
    st_en     = 1'b0;
    st_len    = 0;
    repeat (5) @(posedge clk);
    #1 rst_n = 1'b1;

    e0 = total_errs();
    wb_access(1'b1, REG_BOOT_PC, 64'h8000_1000);
    wb_access(1'b1, REG_CTRL, 64'd1);
    run_xfers(100);
    wb_access(1'b0, REG_CTRL, '0);
    wb_access(1'b0, REG_BOOT_PC, '0);
    report(1, "boot", e0);

    e0 = total_errs();
    bp_en = 1'b1;
    run_xfers(200);
    report(2, "backpressure", e0);

    e0 = total_errs();
    br_en = 1'b1;
    run_xfers(200);
    br_en = 1'b0;
    report(3, "branch", e0);

    e0 = total_errs();
    st_en = 1'b1;
    run_xfers(200);
    st_en = 1'b0;
    bp_en = 1'b0;
    report(4, "br_stall", e0);

    e0 = total_errs();
    wb_access(1'b1, REG_CTRL, 64'd0);
    base = xfer_cnt;
    drain();
    if (xfer_cnt - base > 1) begin
      $display("fetch delivered %0d instructions after it was disabled", xfer_cnt - base);
      local_err++;
    end
    wb_access(1'b1, REG_BOOT_PC, 64'h8000_4004); // start in the upper half
    wb_access(1'b1, REG_CTRL, 64'd1);
    run_xfers(100);
    report(5, "disable", e0);

    e0 = total_errs();
    wb_access(1'b1, REG_CTRL, 64'd0);
    drain();
    wb_access(1'b0, REG_CTRL, '0);
    wb_access(1'b0, REG_BOOT_PC, '0);
    wb_access(1'b0, REG_FETCH_CNT, '0);
    wb_access(1'b0, REG_STALL_CNT, '0);
    wb_access(1'b0, 4'h6, '0); // unmapped offset in the boot pc word
    report(6, "registers", e0);

    $display("tests run 6, failed %0d, errors %0d", tests_failed, total_errs());
    if (tests_failed == 0 && total_errs() == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

// ==== filelist.f ====
verilog/fetch_pkg.sv
verilog/fetch_pc.sv
verilog/fetch_stage.sv
verilog/fetch_csr.sv
verilog/fetch_top.sv
dv/fetch_props.sv
dv/fetch_checker.sv
dv/tb_fetch.sv

// ==== Makefile ====
SIM      ?= verilator
FLAGS    ?= --binary --timing --assert -Wno-fatal
TOP      ?= tb_fetch
FILELIST ?= filelist.f
BUILD    ?= obj_dir
LOG      ?= sim.log
RUNOPTS  ?= +verilator+error+limit+1000

.PHONY: help test clean

help:
	@echo "make test   build with $(SIM) and run $(TOP), pass if the log shows the pass line"
	@echo "make clean  remove build output and log"
	@echo "make help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) $(RUNOPTS) | tee $(LOG)
	grep -q "^Test OK$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
